/* hdl/soc_pkg.sv */
package soc_pkg;

   ////////////////////
   // bus widths
   ////////////////////

   localparam int data_w = 32;
   localparam int addr_w = 16;
   localparam int strb_w = data_w / 8;

   // region select, taken from address bit 15
   typedef enum logic {
      region_mem    = 1'b0,
      region_periph = 1'b1
   } region_e;

   // UART register numbers
   typedef enum logic [1:0] {
      reg_txdata = 2'd0,
      reg_status = 2'd1
   } uart_reg_e;

   ////////////////////
   // address word
   ////////////////////

   // memory view: word index and byte offset
   // peripheral view: register number, with the high field unused
   typedef union packed {
      struct packed {
         region_e     region;
         logic [12:0] word;
         logic [1:0]  offset;
      } mem;
      struct packed {
         region_e     region;
         logic [10:0] high;
         uart_reg_e   reg_num;
         logic [1:0]  offset;
      } periph;
   } soc_addr_u;

endpackage

/* hdl/native_bus_if.sv */
`timescale 1ns/1ns

interface native_bus_if;
   import soc_pkg::*;

   // request
   logic              valid;
   soc_addr_u         addr;
   logic [data_w-1:0] wdata;
   logic [strb_w-1:0] wstrb;

   // response, ready is a single-cycle pulse
   logic [data_w-1:0] rdata;
   logic              ready;

   modport master (
      output valid,
      output addr,
      output wdata,
      output wstrb,
      input  rdata,
      input  ready
   );

   modport slave (
      input  valid,
      input  addr,
      input  wdata,
      input  wstrb,
      output rdata,
      output ready
   );

endinterface

/* hdl/bus_split.sv */
`timescale 1ns/1ns

module bus_split (
   input  logic         clk,
   input  logic         arst_n,
   native_bus_if.slave  cpu,
   native_bus_if.master mem_bus,
   native_bus_if.master uart_bus,
   output logic         bus_err
);
   import soc_pkg::*;

   logic sel_periph;
   logic unmapped;
   logic err_ready_q;
   logic err_done_q;
   logic err_q;

   ////////////////////
   // address decode
   ////////////////////

   assign sel_periph = cpu.addr.mem.region == region_periph;

   // only txdata and status exist in the peripheral region
   assign unmapped = sel_periph &&
                     (cpu.addr.periph.high != '0 || cpu.addr.periph.reg_num > reg_status);

   // request fan-out, valid goes to one slave only
   assign mem_bus.valid  = cpu.valid && !sel_periph;
   assign mem_bus.addr   = cpu.addr;
   assign mem_bus.wdata  = cpu.wdata;
   assign mem_bus.wstrb  = cpu.wstrb;

   assign uart_bus.valid = cpu.valid && sel_periph && !unmapped;
   assign uart_bus.addr  = cpu.addr;
   assign uart_bus.wdata = cpu.wdata;
   assign uart_bus.wstrb = cpu.wstrb;

   ////////////////////
   // response mux
   ////////////////////

   always_comb begin
      if (!sel_periph) begin
         cpu.rdata = mem_bus.rdata;
         cpu.ready = mem_bus.ready;
      end else if (unmapped) begin
         cpu.rdata = '0;
         cpu.ready = err_ready_q;
      end else begin
         cpu.rdata = uart_bus.rdata;
         cpu.ready = uart_bus.ready;
      end
   end

   // local answer for unmapped addresses
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         err_ready_q <= 1'b0;
         err_done_q  <= 1'b0;
         err_q       <= 1'b0;
      end else begin
         err_ready_q <= cpu.valid && unmapped && !err_ready_q && !err_done_q;
         err_done_q  <= cpu.valid && (err_done_q || err_ready_q);
         // sticky until reset
         if (cpu.valid && unmapped) begin
            err_q <= 1'b1;
         end
      end
   end

   assign bus_err = err_q;

   // the two slaves never answer together
   assert property (@(posedge clk) disable iff (!arst_n)
      !(mem_bus.ready && uart_bus.ready));

endmodule

/* hdl/int_mem.sv */
`timescale 1ns/1ns

module int_mem #(
   parameter int mem_words = 1024
) (
   input  logic        clk,
   input  logic        arst_n,
   native_bus_if.slave bus
);
   import soc_pkg::*;

   localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

   logic [data_w-1:0] mem_q [mem_words];
   logic [data_w-1:0] rdata_q;
   logic [idx_w-1:0]  idx;
   logic              accept;
   logic              ready_q;
   logic              done_q;

   // higher word indexes alias onto the array
   assign idx = idx_w'(bus.addr.mem.word % mem_words);

   // first cycle of a new request
   assign accept = bus.valid && !ready_q && !done_q;

   ////////////////////
   // storage
   ////////////////////

   always_ff @(posedge clk) begin
      if (accept) begin
         for (int b = 0; b < strb_w; b++) begin
            if (bus.wstrb[b]) begin
               mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
         end
         rdata_q <= mem_q[idx];
      end
   end

   ////////////////////
   // handshake
   ////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready_q <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         ready_q <= accept;
         // hold off until the master drops valid
         done_q  <= bus.valid && (done_q || ready_q);
      end
   end

   assign bus.rdata = rdata_q;
   assign bus.ready = ready_q;

   // master keeps the address while waiting
   assert property (@(posedge clk) disable iff (!arst_n)
      (bus.valid && !bus.ready) |=> $stable(bus.addr));

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
   parameter int baud_div = 16
) (
   input  logic        clk,
   input  logic        arst_n,
   native_bus_if.slave bus,
   output logic        txd
);
   import soc_pkg::*;

   localparam int cnt_w = (baud_div > 1) ? $clog2(baud_div) : 1;

   localparam logic [1:0] st_idle  = 2'd0;
   localparam logic [1:0] st_start = 2'd1;
   localparam logic [1:0] st_data  = 2'd2;
   localparam logic [1:0] st_stop  = 2'd3;

   logic [1:0]        state_q;
   logic [cnt_w-1:0]  baud_cnt_q;
   logic [2:0]        bit_cnt_q;
   logic [7:0]        shift_q;
   logic [7:0]        txdata_q;
   logic [data_w-1:0] rdata_q;
   logic              ready_q;
   logic              done_q;
   logic              txd_q;
   logic              accept;
   logic              is_write;
   logic              txdata_sel;
   logic              load;
   logic              bit_end;
   logic              busy;

   ////////////////////
   // register access
   ////////////////////

   assign busy       = state_q != st_idle;
   assign accept     = bus.valid && !ready_q && !done_q;
   assign is_write   = |bus.wstrb;
   assign txdata_sel = bus.addr.periph.reg_num == reg_txdata;
   assign load       = accept && is_write && txdata_sel && !busy;
   assign bit_end    = baud_cnt_q == cnt_w'(baud_div - 1);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready_q <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         // txdata write stalls while a frame is on the line
         ready_q <= accept && !(is_write && txdata_sel && busy);
         done_q  <= bus.valid && (done_q || ready_q);
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         txdata_q <= bus.wdata[7:0];
         shift_q  <= bus.wdata[7:0];
      end else if (state_q == st_data && bit_end) begin
         shift_q <= {1'b0, shift_q[7:1]};
      end
      if (accept) begin
         case (bus.addr.periph.reg_num)
            reg_txdata: rdata_q <= data_w'(txdata_q);
            reg_status: rdata_q <= data_w'(busy);
            default:    rdata_q <= '0;
         endcase
      end
   end

   assign bus.rdata = rdata_q;
   assign bus.ready = ready_q;

   ////////////////////
   // frame FSM
   ////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q    <= st_idle;
         baud_cnt_q <= '0;
         bit_cnt_q  <= '0;
         txd_q      <= 1'b1;
      end else begin
         if (state_q == st_idle || bit_end) begin
            baud_cnt_q <= '0;
         end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
         end
         case (state_q)
            st_idle: begin
               if (load) begin
                  state_q <= st_start;
                  txd_q   <= 1'b0;
               end
            end
            st_start: begin
               if (bit_end) begin
                  state_q   <= st_data;
                  bit_cnt_q <= '0;
                  txd_q     <= shift_q[0];
               end
            end
            st_data: begin
               if (bit_end) begin
                  // lsb first, last bit goes to stop
                  if (bit_cnt_q == 3'd7) begin
                     state_q <= st_stop;
                     txd_q   <= 1'b1;
                  end else begin
                     bit_cnt_q <= bit_cnt_q + 1'b1;
                     txd_q     <= shift_q[1];
                  end
               end
            end
            default: begin
               if (bit_end) begin
                  state_q <= st_idle;
               end
            end
         endcase
      end
   end

   assign txd = txd_q;

   // line rests high between frames
   assert property (@(posedge clk) disable iff (!arst_n)
      (state_q == st_idle) |-> txd_q);

endmodule

/* hdl/soc_top.sv */
`timescale 1ns/1ns

module soc_top #(
   parameter int mem_words = 1024,
   parameter int baud_div  = 16
) (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        bus_valid,
   input  logic [soc_pkg::addr_w-1:0]  bus_addr,
   input  logic [soc_pkg::data_w-1:0]  bus_wdata,
   input  logic [soc_pkg::strb_w-1:0]  bus_wstrb,
   output logic [soc_pkg::data_w-1:0]  bus_rdata,
   output logic                        bus_ready,
   output logic                        bus_err,
   output logic                        uart_txd
);

   native_bus_if cpu_bus ();
   native_bus_if mem_bus ();
   native_bus_if uart_bus ();

   ////////////////////
   // processor link
   ////////////////////

   assign cpu_bus.valid = bus_valid;
   assign cpu_bus.addr  = bus_addr;
   assign cpu_bus.wdata = bus_wdata;
   assign cpu_bus.wstrb = bus_wstrb;
   assign bus_rdata     = cpu_bus.rdata;
   assign bus_ready     = cpu_bus.ready;

   // memory and peripheral split
   bus_split i_bus_split (
      .clk      (clk),
      .arst_n   (arst_n),
      .cpu      (cpu_bus.slave),
      .mem_bus  (mem_bus.master),
      .uart_bus (uart_bus.master),
      .bus_err  (bus_err)
   );

   ////////////////////
   // slaves
   ////////////////////

   int_mem #(
      .mem_words (mem_words)
   ) i_int_mem (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (mem_bus.slave)
   );

   uart_tx #(
      .baud_div (baud_div)
   ) i_uart_tx (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (uart_bus.slave),
      .txd    (uart_txd)
   );

endmodule

/* test/tb_soc_top.sv */
`timescale 1ns/1ns

module tb_soc_top;
   import soc_pkg::*;

   localparam int mem_words   = 1024;
   localparam int baud_div    = 16;
   localparam int clk_period  = 10;
   localparam int frame_len   = 10 * baud_div;
   localparam int ready_limit = frame_len + 4 * baud_div;
   // reset, about 90 bus accesses of 3 cycles, four frames, then margin
   localparam int run_cycles  = 10 + 90 * 3 + 4 * frame_len + 500;
   // valid is seen one edge after it is driven and ready rises on that edge
   localparam int ready_waits = 2;

   localparam logic [addr_w-1:0] addr_txdata = 16'h8000;
   localparam logic [addr_w-1:0] addr_status = 16'h8004;
   localparam logic [addr_w-1:0] addr_reg3   = 16'h800c;
   localparam logic [addr_w-1:0] addr_high   = 16'h8010;

   logic              clk;
   logic              arst_n;
   logic              bus_valid;
   logic [addr_w-1:0] bus_addr;
   logic [data_w-1:0] bus_wdata;
   logic [strb_w-1:0] bus_wstrb;
   logic [data_w-1:0] bus_rdata;
   logic              bus_ready;
   logic              bus_err;
   logic              uart_txd;

   logic [15:0]       lfsr_q;
   logic [data_w-1:0] model [mem_words];
   int                idx_q [$];
   int                word_errs;
   int                bit_errs;
   int                byte_errs;
   int                bus_errs;

   soc_top #(
      .mem_words (mem_words),
      .baud_div  (baud_div)
   ) i_soc_top (
      .clk       (clk),
      .arst_n    (arst_n),
      .bus_valid (bus_valid),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_wstrb (bus_wstrb),
      .bus_rdata (bus_rdata),
      .bus_ready (bus_ready),
      .bus_err   (bus_err),
      .uart_txd  (uart_txd)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   ////////////////////
   // helpers
   ////////////////////

   // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   task automatic check_word(input string msg, input logic [data_w-1:0] got,
                             input logic [data_w-1:0] exp);
      if (got !== exp) begin
         word_errs++;
         $display("mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_bit(input string msg, input logic got, input logic exp);
      if (got !== exp) begin
         bit_errs++;
         $display("mismatch at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      end
   endtask

   task automatic check_byte(input string msg, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         byte_errs++;
         $display("mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   // one bus transfer that reads when the strobe is zero
   task automatic bus_access(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
                             input logic [strb_w-1:0] wstrb,
                             output logic [data_w-1:0] rdata, output int waits);
      waits = 0;
      rdata = '0;
      @(posedge clk);
      bus_valid <= 1'b1;
      bus_addr  <= addr;
      bus_wdata <= wdata;
      bus_wstrb <= wstrb;
      do begin
         @(negedge clk);
         waits++;
      end while (!bus_ready && waits < ready_limit);
      if (bus_ready) begin
         rdata = bus_rdata;
      end else begin
         bus_errs++;
         $display("ready never came for address %h within %0d cycles", addr, ready_limit);
      end
      @(posedge clk);
      bus_valid <= 1'b0;
      bus_wstrb <= '0;
   endtask

   // waits for the start edge, then samples mid-bit
   task automatic uart_receive(output logic [7:0] data, output logic stop);
      @(negedge uart_txd);
      repeat (baud_div / 2) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
         repeat (baud_div) @(negedge clk);
         data[i] = uart_txd;
      end
      repeat (baud_div) @(negedge clk);
      stop = uart_txd;
   endtask

   ////////////////////
   // tests
   ////////////////////

   task automatic test_reset();
      @(negedge clk);
      check_bit("ready after reset", bus_ready, 1'b0);
      check_bit("bus_err after reset", bus_err, 1'b0);
      check_bit("txd after reset", uart_txd, 1'b1);
   endtask

   task automatic test_memory();
      int                idx;
      int                waits;
      logic [data_w-1:0] wdata;
      logic [data_w-1:0] rdata;
      logic [strb_w-1:0] strb;
      for (int n = 0; n < 32; n++) begin
         idx   = int'(rand_bits(10));
         wdata = rand_bits(32);
         bus_access(addr_w'(idx * 4), wdata, '1, rdata, waits);
         check_bit("memory write latency", waits == ready_waits, 1'b1);
         model[idx] = wdata;
         idx_q.push_back(idx);
      end
      // partial writes merge only the strobed bytes into the model
      for (int n = 0; n < 16; n++) begin
         idx   = idx_q[n];
         wdata = rand_bits(32);
         strb  = strb_w'(rand_bits(4));
         if (strb == '0) begin
            strb = 4'b0001;
         end
         bus_access(addr_w'(idx * 4), wdata, strb, rdata, waits);
         for (int b = 0; b < strb_w; b++) begin
            if (strb[b]) begin
               model[idx][8*b +: 8] = wdata[8*b +: 8];
            end
         end
      end
      foreach (idx_q[n]) begin
         bus_access(addr_w'(idx_q[n] * 4), '0, '0, rdata, waits);
         check_word($sformatf("memory word %0d", idx_q[n]), rdata, model[idx_q[n]]);
         check_bit("memory read latency", waits == ready_waits, 1'b1);
      end
      idx = idx_q[0];
      bus_access(addr_w'((idx + mem_words) * 4), '0, '0, rdata, waits);
      check_word("aliased memory word", rdata, model[idx]);
   endtask

   task automatic test_uart_frame();
      logic [data_w-1:0] wdata;
      logic [data_w-1:0] rdata;
      logic [7:0]        rx;
      logic              stop;
      int                waits;
      wdata = rand_bits(32);
      fork
         uart_receive(rx, stop);
         bus_access(addr_txdata, wdata, '1, rdata, waits);
      join
      check_bit("idle txdata write latency", waits == ready_waits, 1'b1);
      check_byte("received byte", rx, wdata[7:0]);
      check_bit("stop bit", stop, 1'b1);
      bus_access(addr_txdata, '0, '0, rdata, waits);
      check_word("txdata readback", rdata, data_w'(wdata[7:0]));
   endtask

   task automatic test_backpressure();
      logic [7:0]        b1;
      logic [7:0]        b2;
      logic [7:0]        rx1;
      logic [7:0]        rx2;
      logic              stop1;
      logic              stop2;
      logic [data_w-1:0] rdata;
      int                waits;
      time               t1;
      b1 = 8'(rand_bits(8));
      b2 = 8'(rand_bits(8));
      fork
         begin
            uart_receive(rx1, stop1);
            uart_receive(rx2, stop2);
         end
         begin
            bus_access(addr_txdata, data_w'(b1), '1, rdata, waits);
            t1 = $time;
            bus_access(addr_status, '0, '0, rdata, waits);
            check_word("status while sending", rdata, data_w'(1));
            check_bit("status read latency", waits == ready_waits, 1'b1);
            // second write has to wait out the whole first frame
            bus_access(addr_txdata, data_w'(b2), '1, rdata, waits);
            check_bit("txdata write held while busy",
                      ($time - t1) >= frame_len * clk_period, 1'b1);
         end
      join
      check_byte("first frame", rx1, b1);
      check_bit("first stop bit", stop1, 1'b1);
      check_byte("second frame", rx2, b2);
      check_bit("second stop bit", stop2, 1'b1);
      repeat (baud_div) @(posedge clk);
      bus_access(addr_status, '0, '0, rdata, waits);
      check_word("status after the frames", rdata, '0);
   endtask

   task automatic test_unmapped();
      logic [data_w-1:0] rdata;
      int                waits;
      check_bit("bus_err before unmapped access", bus_err, 1'b0);
      bus_access(addr_reg3, '0, '0, rdata, waits);
      check_word("unmapped register 3", rdata, '0);
      check_bit("bus_err after register 3", bus_err, 1'b1);
      check_bit("unmapped ready latency", waits == ready_waits, 1'b1);
      bus_access(addr_high, '0, '0, rdata, waits);
      check_word("nonzero high field", rdata, '0);
      // flag stays set and normal traffic is still answered
      bus_access(addr_w'(idx_q[1] * 4), '0, '0, rdata, waits);
      check_word("memory after unmapped access", rdata, model[idx_q[1]]);
      check_bit("bus_err stays set", bus_err, 1'b1);
      bus_access(addr_status, '0, '0, rdata, waits);
      check_word("status after unmapped access", rdata, '0);
      check_bit("bus_err still set", bus_err, 1'b1);
   endtask

   ////////////////////
   // run
   ////////////////////

   initial begin
      lfsr_q    = 16'd22;
      word_errs = 0;
      bit_errs  = 0;
      byte_errs = 0;
      bus_errs  = 0;
      arst_n    = 1'b0;
      bus_valid = 1'b0;
      bus_addr  = '0;
      bus_wdata = '0;
      bus_wstrb = '0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      test_reset();
      test_memory();
      test_uart_frame();
      test_backpressure();
      test_unmapped();
      $display("errors: word %0d, bit %0d, byte %0d, bus %0d",
               word_errs, bit_errs, byte_errs, bus_errs);
      if (word_errs + bit_errs + byte_errs + bus_errs == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(run_cycles * clk_period);
      $display("watchdog expired, tests did not finish within %0d cycles", run_cycles);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* files.f */
hdl/soc_pkg.sv
hdl/native_bus_if.sv
hdl/bus_split.sv
hdl/int_mem.sv
hdl/uart_tx.sv
hdl/soc_top.sv
test/tb_soc_top.sv

/* Bender.yml */
package:
  name: soc_fabric

sources:
  - hdl/soc_pkg.sv
  - hdl/native_bus_if.sv
  - hdl/bus_split.sv
  - hdl/int_mem.sv
  - hdl/uart_tx.sv
  - hdl/soc_top.sv
  - target: test
    files:
      - test/tb_soc_top.sv
